//--- logic/column_ctrl_if.sv
`default_nettype none

interface column_ctrl_if
    import line_window_pkg::*;
();

    // Column step controls from the sequencer
    logic      shift;
    logic      pad_column;
    logic      bottom_pad;
    logic      write;
    logic      clear_upper;
    col_addr_t col_addr;
    logic      emit;

    // Stored rows n-2 and n-1 at col_addr
    pixel_t    upper_pixel;
    pixel_t    lower_pixel;

    modport sequencer (
        output shift, pad_column, bottom_pad, write, clear_upper, col_addr, emit
    );

    modport memory (
        input  write, clear_upper, col_addr,
        output upper_pixel, lower_pixel
    );

    modport shifter (
        input shift, pad_column, bottom_pad, emit, upper_pixel, lower_pixel
    );

endinterface

`default_nettype wire

//--- logic/line_memory.sv
`default_nettype none

`include "line_window_cfg.svh"

module line_memory
    import line_window_pkg::*;
(
    input  logic          clk,
    input  pixel_t        pixel_in,
    column_ctrl_if.memory ctrl
);

    // Row n-2
    pixel_t upper_row [`MAX_COLS];

    // Row n-1
    pixel_t lower_row [`MAX_COLS];

    pixel_t upper_next;

    assign ctrl.upper_pixel = upper_row[ctrl.col_addr];
    assign ctrl.lower_pixel = lower_row[ctrl.col_addr];

    // First row puts zeros above itself
    assign upper_next = ctrl.clear_upper ? '0 : lower_row[ctrl.col_addr];

    // Rows move down one column per write
    always_ff @(posedge clk) begin
        if (ctrl.write) begin
            upper_row[ctrl.col_addr] <= upper_next;
            lower_row[ctrl.col_addr] <= pixel_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/line_window_cfg.svh
`ifndef LINE_WINDOW_CFG_SVH
`define LINE_WINDOW_CFG_SVH

// Bits per pixel
`define PIXEL_WIDTH 8

// Column index and image width
`define COL_ADDR_WIDTH 8

// Depth of each stored row
`define MAX_COLS 256

// Window is WINDOW_SIZE x WINDOW_SIZE pixels
`define WINDOW_SIZE 3

`endif

//--- logic/line_window_pkg.sv
`default_nettype none

`include "line_window_cfg.svh"

package line_window_pkg;

    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    typedef logic [`COL_ADDR_WIDTH-1:0] col_addr_t;

    // Element (r, c) at index r*3 + c, lowest index in the lowest bits
    typedef logic [`PIXEL_WIDTH*`WINDOW_SIZE*`WINDOW_SIZE-1:0] window_t;

    typedef enum logic [1:0] {
        IDLE,
        PAD_LEFT,
        STREAM,
        PAD_RIGHT
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/line_window_top.sv
`default_nettype none

module line_window_top
    import line_window_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  col_addr_t image_size,

    // Row commands, honoured while idle
    input  logic      stream_first_row,
    input  logic      stream_mid_row,
    input  logic      stream_last_row,

    // Pixel stream in
    input  pixel_t    s_axis_tdata,
    input  logic      s_axis_tvalid,
    output logic      s_axis_tready,

    // Window stream out
    output window_t   window_data,
    output logic      window_valid,

    output logic      done_row,
    output logic      idle
);

    column_ctrl_if ctrl_if ();

    row_sequencer row_sequencer_i (
        .clk              (clk),
        .reset            (reset),
        .image_size       (image_size),
        .stream_first_row (stream_first_row),
        .stream_mid_row   (stream_mid_row),
        .stream_last_row  (stream_last_row),
        .s_axis_tvalid    (s_axis_tvalid),
        .s_axis_tready    (s_axis_tready),
        .done_row         (done_row),
        .idle             (idle),
        .ctrl             (ctrl_if.sequencer)
    );

    line_memory line_memory_i (
        .clk      (clk),
        .pixel_in (s_axis_tdata),
        .ctrl     (ctrl_if.memory)
    );

    // Input pixel also feeds the bottom row of the window directly
    window_shifter window_shifter_i (
        .clk          (clk),
        .reset        (reset),
        .pixel_in     (s_axis_tdata),
        .window       (window_data),
        .window_valid (window_valid),
        .ctrl         (ctrl_if.shifter)
    );

endmodule

`default_nettype wire

//--- logic/row_sequencer.sv
`default_nettype none

module row_sequencer
    import line_window_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  col_addr_t        image_size,
    input  logic             stream_first_row,
    input  logic             stream_mid_row,
    input  logic             stream_last_row,
    input  logic             s_axis_tvalid,
    output logic             s_axis_tready,
    output logic             done_row,
    output logic             idle,
    column_ctrl_if.sequencer ctrl
);

    typedef enum logic [1:0] {
        MODE_FIRST,
        MODE_MID,
        MODE_LAST
    } row_mode_t;

    seq_state_t state;
    seq_state_t state_next;
    row_mode_t  mode;
    col_addr_t  col_cnt;
    col_addr_t  last_col;
    logic       at_last_col;
    logic       col_step;
    logic       row_end;

    assign last_col    = image_size - col_addr_t'(1);
    assign at_last_col = (col_cnt == last_col);

    assign idle          = (state == IDLE);
    assign ctrl.col_addr = col_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            mode     <= MODE_FIRST;
            col_cnt  <= '0;
            done_row <= 1'b0;
        end else begin
            state    <= state_next;
            done_row <= row_end;

            if (state == IDLE) begin
                col_cnt <= '0;
                // Command priority: first, middle, last
                if (stream_first_row) begin
                    mode <= MODE_FIRST;
                end else if (stream_mid_row) begin
                    mode <= MODE_MID;
                end else if (stream_last_row) begin
                    mode <= MODE_LAST;
                end
            end else if (col_step) begin
                if (at_last_col) begin
                    col_cnt <= '0;
                end else begin
                    col_cnt <= col_cnt + col_addr_t'(1);
                end
            end
        end
    end

    always_comb begin
        state_next       = state;
        s_axis_tready    = 1'b0;
        col_step         = 1'b0;
        row_end          = 1'b0;
        ctrl.shift       = 1'b0;
        ctrl.pad_column  = 1'b0;
        ctrl.bottom_pad  = 1'b0;
        ctrl.write       = 1'b0;
        ctrl.clear_upper = 1'b0;
        ctrl.emit        = 1'b0;

        case (state)
            IDLE: begin
                if (stream_first_row) begin
                    state_next = STREAM;
                end else if (stream_mid_row || stream_last_row) begin
                    state_next = PAD_LEFT;
                end
            end

            // Zero column for the left image edge
            PAD_LEFT: begin
                ctrl.shift      = 1'b1;
                ctrl.pad_column = 1'b1;
                state_next      = STREAM;
            end

            STREAM: begin
                if (mode == MODE_LAST) begin
                    // No input, one column per cycle with a zero bottom row
                    col_step        = 1'b1;
                    ctrl.shift      = 1'b1;
                    ctrl.bottom_pad = 1'b1;
                    ctrl.emit       = (col_cnt != '0);
                end else begin
                    s_axis_tready    = 1'b1;
                    col_step         = s_axis_tvalid;
                    ctrl.write       = s_axis_tvalid;
                    ctrl.clear_upper = (mode == MODE_FIRST);
                    if (mode == MODE_MID) begin
                        ctrl.shift = s_axis_tvalid;
                        ctrl.emit  = s_axis_tvalid && (col_cnt != '0);
                    end
                end

                if (col_step && at_last_col) begin
                    state_next = PAD_RIGHT;
                    row_end    = (mode == MODE_FIRST);
                end
            end

            // Right image edge, first rows only wait here
            PAD_RIGHT: begin
                if (mode != MODE_FIRST) begin
                    ctrl.shift      = 1'b1;
                    ctrl.pad_column = 1'b1;
                    ctrl.emit       = 1'b1;
                    row_end         = 1'b1;
                end
                state_next = IDLE;
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/window_shifter.sv
`default_nettype none

`include "line_window_cfg.svh"

module window_shifter
    import line_window_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  pixel_t         pixel_in,
    output window_t        window,
    output logic           window_valid,
    column_ctrl_if.shifter ctrl
);

    localparam int N = `WINDOW_SIZE;

    // Indexed [row][column], column N-1 is the newest
    pixel_t win_q   [N][N];
    pixel_t new_col [N];

    always_comb begin
        if (ctrl.pad_column) begin
            new_col[0]   = '0;
            new_col[1]   = '0;
            new_col[N-1] = '0;
        end else begin
            new_col[0]   = ctrl.upper_pixel;
            new_col[1]   = ctrl.lower_pixel;
            new_col[N-1] = ctrl.bottom_pad ? '0 : pixel_in;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.shift) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][N-1] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= ctrl.emit;
        end
    end

    // Flatten row-major, top left in the lowest bits
    always_comb begin
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                window[(r*N+c)*`PIXEL_WIDTH +: `PIXEL_WIDTH] = win_q[r][c];
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the line window testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module line_window_tb -f sim.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vline_window_tb)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qF 'All tests passed!'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- sim.f
+incdir+logic
logic/line_window_pkg.sv
logic/column_ctrl_if.sv
logic/row_sequencer.sv
logic/line_memory.sv
logic/window_shifter.sv
logic/line_window_top.sv
verification/line_window_tb.sv

//--- verification/line_window_tb.sv
`default_nettype none

`include "line_window_cfg.svh"

module line_window_tb
    import line_window_pkg::*;
();

    localparam int DRIVE_DELAY = 10;
    localparam int ROW_TIMEOUT = 4000;

    localparam int KIND_FIRST = 0;
    localparam int KIND_MID   = 1;
    localparam int KIND_LAST  = 2;

    logic      clk;
    logic      reset;
    col_addr_t image_size;
    logic      stream_first_row;
    logic      stream_mid_row;
    logic      stream_last_row;
    pixel_t    s_axis_tdata;
    logic      s_axis_tvalid;
    logic      s_axis_tready;
    window_t   window_data;
    logic      window_valid;
    logic      done_row;
    logic      idle;

    // Reference model of the two stored rows and the row being sent
    pixel_t  older_row    [`MAX_COLS];
    pixel_t  newer_row    [`MAX_COLS];
    pixel_t  incoming_row [`MAX_COLS];
    window_t exp_windows  [`MAX_COLS];

    logic [31:0] lfsr_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    line_window_top line_window_top_i (
        .clk              (clk),
        .reset            (reset),
        .image_size       (image_size),
        .stream_first_row (stream_first_row),
        .stream_mid_row   (stream_mid_row),
        .stream_last_row  (stream_last_row),
        .s_axis_tdata     (s_axis_tdata),
        .s_axis_tvalid    (s_axis_tvalid),
        .s_axis_tready    (s_axis_tready),
        .window_data      (window_data),
        .window_valid     (window_valid),
        .done_row         (done_row),
        .idle             (idle)
    );

    initial clk = 1'b0;

    always #50 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic pixel_t random_pixel();
        pixel_t p;
        p = '0;
        for (int i = 0; i < `PIXEL_WIDTH; i++) begin
            p = {p[`PIXEL_WIDTH-2:0], next_bit()};
        end
        return p;
    endfunction

    // Zero outside the image on every side
    function automatic pixel_t model_pixel(input int r, input int col, input int width,
                                           input logic bottom_zero);
        pixel_t p;
        if (col < 0 || col >= width) begin
            p = '0;
        end else if (r == 0) begin
            p = older_row[col];
        end else if (r == 1) begin
            p = newer_row[col];
        end else if (bottom_zero) begin
            p = '0;
        end else begin
            p = incoming_row[col];
        end
        return p;
    endfunction

    function automatic window_t model_window(input int center, input int width,
                                             input logic bottom_zero);
        window_t w;
        w = '0;
        for (int r = 0; r < `WINDOW_SIZE; r++) begin
            for (int c = 0; c < `WINDOW_SIZE; c++) begin
                w[(r*`WINDOW_SIZE+c)*`PIXEL_WIDTH +: `PIXEL_WIDTH] =
                    model_pixel(r, center - 1 + c, width, bottom_zero);
            end
        end
        return w;
    endfunction

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (error_count == start_errors) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL (%0d errors)", tests_run, name,
                     error_count - start_errors);
        end
    endtask

    // Sends one row command and checks the row once per cycle until it ends
    task automatic run_row(input int kind, input int width);
        int   accepted;
        int   win_cnt;
        int   done_cnt;
        int   cycles;
        logic ready_seen;
        logic finished;
        accepted   = 0;
        win_cnt    = 0;
        done_cnt   = 0;
        cycles     = 1;
        ready_seen = 1'b0;
        finished   = 1'b0;
        if (timed_out) begin
            return;
        end
        image_size = col_addr_t'(width);
        for (int i = 0; i < width; i++) begin
            incoming_row[i] = random_pixel();
        end
        if (kind != KIND_FIRST) begin
            for (int k = 0; k < width; k++) begin
                exp_windows[k] = model_window(k, width, kind == KIND_LAST);
            end
        end
        stream_first_row = (kind == KIND_FIRST);
        stream_mid_row   = (kind == KIND_MID);
        stream_last_row  = (kind == KIND_LAST);
        @(posedge clk);
        #DRIVE_DELAY;
        stream_first_row = 1'b0;
        stream_mid_row   = 1'b0;
        stream_last_row  = 1'b0;
        expect_true(!idle, "idle still high the cycle after a row command");

        while (!finished) begin
            if (s_axis_tvalid && ready_seen) begin
                accepted++;
                s_axis_tvalid = 1'b0;
            end
            if (window_valid) begin
                expect_true(kind != KIND_FIRST, "window_valid during a first row");
                if (win_cnt < width) begin
                    expect_true(window_data == exp_windows[win_cnt],
                                $sformatf("window %0d is %h, expected %h", win_cnt,
                                          window_data, exp_windows[win_cnt]));
                end else begin
                    expect_true(1'b0, "more windows than image columns");
                end
                win_cnt++;
            end
            if (done_row) begin
                done_cnt++;
                if (kind == KIND_FIRST) begin
                    expect_true(accepted == width, "done_row before the row was taken");
                end else begin
                    expect_true(window_valid && win_cnt == width,
                                "done_row not on the last window");
                end
                if (kind == KIND_LAST) begin
                    // Edges from the command edge to the final window
                    expect_true(cycles - 1 == width + 2,
                                $sformatf("last row took %0d cycles", cycles - 1));
                end
            end
            if (kind == KIND_LAST || accepted == width) begin
                expect_true(!s_axis_tready, "s_axis_tready high with no pixel due");
            end else if (kind == KIND_FIRST || cycles >= 2) begin
                expect_true(s_axis_tready, "s_axis_tready low while pixels are due");
            end

            if (done_cnt > 0 && idle) begin
                finished = 1'b1;
            end else if (cycles >= ROW_TIMEOUT) begin
                $display("Timeout: row did not finish within %0d cycles", ROW_TIMEOUT);
                error_count++;
                timed_out = 1'b1;
                finished  = 1'b1;
            end else begin
                if (kind == KIND_LAST) begin
                    // Offered pixels must be ignored
                    s_axis_tvalid = next_bit();
                    s_axis_tdata  = random_pixel();
                end else if (accepted < width) begin
                    if (!s_axis_tvalid) begin
                        s_axis_tvalid = next_bit();
                    end
                    s_axis_tdata = s_axis_tvalid ? incoming_row[accepted]
                                                 : ~incoming_row[accepted];
                end
                ready_seen = s_axis_tready;
                @(posedge clk);
                #DRIVE_DELAY;
                cycles++;
            end
        end
        s_axis_tvalid = 1'b0;

        if (!timed_out) begin
            expect_true(done_cnt == 1, $sformatf("done_row pulsed %0d times", done_cnt));
            expect_true(accepted == (kind == KIND_LAST ? 0 : width),
                        $sformatf("%0d pixels accepted", accepted));
            expect_true(win_cnt == (kind == KIND_FIRST ? 0 : width),
                        $sformatf("%0d windows seen", win_cnt));
            for (int i = 0; i < width; i++) begin
                if (kind == KIND_FIRST) begin
                    older_row[i] = '0;
                end else if (kind == KIND_MID) begin
                    older_row[i] = newer_row[i];
                end
                if (kind != KIND_LAST) begin
                    newer_row[i] = incoming_row[i];
                end
            end
        end
    endtask

    initial begin
        int start_errors;
        lfsr_state       = 32'hb315;
        error_count      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        timed_out        = 1'b0;
        reset            = 1'b1;
        image_size       = '0;
        stream_first_row = 1'b0;
        stream_mid_row   = 1'b0;
        stream_last_row  = 1'b0;
        s_axis_tdata     = '0;
        s_axis_tvalid    = 1'b0;

        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        start_errors = error_count;
        expect_true(idle, "idle low after reset");
        expect_true(!s_axis_tready, "s_axis_tready high after reset");
        expect_true(!window_valid, "window_valid high after reset");
        expect_true(!done_row, "done_row high after reset");
        report_test("reset state", start_errors);

        start_errors = error_count;
        run_row(KIND_FIRST, 16);
        report_test("first row", start_errors);

        start_errors = error_count;
        repeat (3) run_row(KIND_MID, 16);
        report_test("middle rows", start_errors);

        start_errors = error_count;
        run_row(KIND_LAST, 16);
        report_test("last row", start_errors);

        // Narrower frames must not see columns of the wide one
        start_errors = error_count;
        run_row(KIND_FIRST, 5);
        repeat (2) run_row(KIND_MID, 5);
        run_row(KIND_LAST, 5);
        run_row(KIND_FIRST, 1);
        run_row(KIND_MID, 1);
        run_row(KIND_LAST, 1);
        report_test("narrow frame after wide frame", start_errors);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
